// File: src/dispatch_pkg.sv
package dispatch_pkg;

   // --------------------
   // Sizes
   // --------------------

   // Converter sources and output channels
   localparam int N_SRC      = 8;
   localparam int N_CHAN     = 8;

   // Sample word width
   localparam int W_DATA     = 18;

   // Input queue entries, a power of two so the pointers wrap by themselves
   localparam int FIFO_DEPTH = 16;

   // Derived widths
   localparam int SRC_W      = $clog2(N_SRC);
   localparam int CHAN_W     = $clog2(N_CHAN);
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // --------------------
   // Types
   // --------------------
   typedef logic [SRC_W-1:0]    src_t;
   // Extra top bit flags an unassigned channel
   typedef logic [SRC_W:0]      sel_t;
   typedef logic [CHAN_W-1:0]   chan_t;
   typedef logic [N_CHAN-1:0]   chan_mask_t;
   typedef logic [W_DATA-1:0]   data_t;
   typedef logic [15:0]         reg_addr_t;
   typedef logic [15:0]         reg_data_t;
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   // One bit wider than the pointer so a full queue can be counted
   typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

   // Select value meaning "drives nothing"
   localparam sel_t NO_SRC = {1'b1, {SRC_W{1'b0}}};

   // --------------------
   // Register map
   // --------------------
   localparam reg_addr_t CHAN_EN_ADDR      = 16'h0010;
   localparam reg_addr_t CHAN_SRC_SEL_ADDR = 16'h0011;

   // Dispatcher FSM
   typedef enum logic [1:0] {IDLE, ISSUE, POP} dispatch_state_t;

endpackage

// File: src/sample_fifo.sv
`timescale 1ns/1ns

module sample_fifo (
   input  logic                clk_in,
   input  logic                arst_n,
   input  logic                dv_in,
   input  dispatch_pkg::src_t  src_in,
   input  dispatch_pkg::data_t data_in,
   input  logic                pop,
   output logic                head_valid,
   output dispatch_pkg::src_t  head_src,
   output dispatch_pkg::data_t head_data,
   output logic                full
);
   import dispatch_pkg::*;

   // --------------------
   // Storage
   // --------------------

   // Tag and sample kept side by side per entry
   src_t      src_mem  [FIFO_DEPTH];
   data_t     data_mem [FIFO_DEPTH];

   // Queue bookkeeping
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_cnt_t count;

   // Qualified strobes
   logic      do_wr;
   logic      do_rd;

   // Samples arriving on a full queue are lost here
   assign do_wr = dv_in && !full;
   // Ignore a stray pop on an empty queue
   assign do_rd = pop && head_valid;

   // Payload write, no reset needed
   always_ff @(posedge clk_in) begin
      if (do_wr) begin
         src_mem[wr_ptr]  <= src_in;
         data_mem[wr_ptr] <= data_in;
      end
   end

   // --------------------
   // Pointers and count
   // --------------------
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at the power-of-two depth
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Write and pop together leave the count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // --------------------
   // Head of queue
   // --------------------

   // Entry written last cycle is already visible
   assign head_valid = (count != '0);
   assign head_src   = src_mem[rd_ptr];
   assign head_data  = data_mem[rd_ptr];

   // Full flag straight from the count
   assign full       = (count == fifo_cnt_t'(FIFO_DEPTH));

endmodule

// File: src/route_map.sv
`timescale 1ns/1ns

module route_map (
   input  logic                      clk_in,
   input  logic                      arst_n,
   input  logic                      wr_en,
   input  dispatch_pkg::reg_addr_t   wr_addr,
   input  dispatch_pkg::reg_addr_t   wr_chan,
   input  dispatch_pkg::reg_data_t   wr_data,
   input  dispatch_pkg::src_t        src,
   output dispatch_pkg::chan_mask_t  chan_mask
);
   import dispatch_pkg::*;

   // --------------------
   // Route registers
   // --------------------

   // One enable bit per output channel
   chan_mask_t chan_en;
   // Source each channel listens to
   sel_t       chan_sel [N_CHAN];

   // Write decode
   logic       wr_chan_ok;
   chan_t      wr_idx;
   logic       wr_en_hit;
   logic       wr_sel_hit;

   // Channel numbers past the table are dropped
   assign wr_chan_ok = (wr_chan < reg_addr_t'(N_CHAN));
   // Low bits index the table once range is checked
   assign wr_idx     = chan_t'(wr_chan);

   // Address match per register
   assign wr_en_hit  = wr_en && wr_chan_ok && (wr_addr == CHAN_EN_ADDR);
   assign wr_sel_hit = wr_en && wr_chan_ok && (wr_addr == CHAN_SRC_SEL_ADDR);

   // Enable bits
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         // All outputs off after reset
         chan_en <= '0;
      end else if (wr_en_hit) begin
         chan_en[wr_idx] <= wr_data[0];
      end
   end

   // Source selects
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         // No channel is bound to a source after reset
         for (int c = 0; c < N_CHAN; c++) begin
            chan_sel[c] <= NO_SRC;
         end
      end else if (wr_sel_hit) begin
         // Bits 3 to 0, top bit parks the channel
         chan_sel[wr_idx] <= sel_t'(wr_data);
      end
   end

   // --------------------
   // Mask lookup
   // --------------------

   // Mask is rebuilt from the selects every cycle
   // Remapping a channel therefore drops it from its old source at once
   always_comb begin
      chan_mask = '0;
      for (int c = 0; c < N_CHAN; c++) begin
         // NO_SRC never matches since the compare value has a zero top bit
         if (chan_en[c] && (chan_sel[c] == {1'b0, src})) begin
            chan_mask[c] = 1'b1;
         end
      end
   end

endmodule

// File: src/dispatch_ctrl.sv
`timescale 1ns/1ns

module dispatch_ctrl (
   input  logic                     clk_in,
   input  logic                     arst_n,
   input  logic                     head_valid,
   input  dispatch_pkg::data_t      head_data,
   input  dispatch_pkg::chan_mask_t chan_mask,
   output logic                     pop,
   output logic                     dv_out,
   output dispatch_pkg::chan_t      chan_out,
   output dispatch_pkg::data_t      data_out
);
   import dispatch_pkg::*;

   dispatch_state_t state;
   dispatch_state_t state_nxt;

   // Channels already served for the head sample
   chan_mask_t      sent;
   // Routed channels still owed an instruction
   chan_mask_t      pending;
   chan_t           next_chan;
   logic            issue;

   // --------------------
   // Channel pick
   // --------------------
   assign pending = chan_mask & ~sent;

   // Lowest pending channel wins
   always_comb begin
      next_chan = '0;
      for (int c = N_CHAN - 1; c >= 0; c--) begin
         if (pending[c]) begin
            next_chan = chan_t'(c);
         end
      end
   end

   // Issue while holding a sample that still has work
   assign issue = (state != POP) && head_valid && (pending != '0);

   // Pop decoded from state, so it is never high with dv_out
   assign pop   = (state == POP);

   // --------------------
   // FSM
   // --------------------
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE, ISSUE: begin
            if (!head_valid) begin
               state_nxt = IDLE;
            end else if (pending != '0) begin
               state_nxt = ISSUE;
            end else begin
               // Mask exhausted or empty, release the head
               state_nxt = POP;
            end
         end
         // New head shows up next cycle
         POP:     state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
         sent  <= '0;
      end else begin
         state <= state_nxt;
         if (pop) begin
            // Fresh slate for the next sample
            sent <= '0;
         end else if (issue) begin
            sent[next_chan] <= 1'b1;
         end
      end
   end

   // --------------------
   // Instruction register
   // --------------------
   always_ff @(posedge clk_in or negedge arst_n) begin
      if (!arst_n) begin
         dv_out   <= 1'b0;
         chan_out <= '0;
         data_out <= '0;
      end else begin
         dv_out <= issue;
         // Hold last instruction between strobes
         if (issue) begin
            chan_out <= next_chan;
            data_out <= head_data;
         end
      end
   end

endmodule

// File: src/instr_dispatch.sv
`timescale 1ns/1ns

module instr_dispatch (
   input  logic                    clk_in,
   input  logic                    arst_n,
   // Sample input
   input  logic                    dv_in,
   input  dispatch_pkg::src_t      src_in,
   input  dispatch_pkg::data_t     data_in,
   // Route table register bus
   input  logic                    wr_en,
   input  dispatch_pkg::reg_addr_t wr_addr,
   input  dispatch_pkg::reg_addr_t wr_chan,
   input  dispatch_pkg::reg_data_t wr_data,
   // Instruction output
   output logic                    dv_out,
   output dispatch_pkg::chan_t     chan_out,
   output dispatch_pkg::data_t     data_out,
   output logic                    full
);
   import dispatch_pkg::*;

   // --------------------
   // Internal nets
   // --------------------
   logic       head_valid;
   src_t       head_src;
   data_t      head_data;
   logic       pop;
   chan_mask_t chan_mask;

   // Input queue
   sample_fifo u_sample_fifo (
      .clk_in     (clk_in),
      .arst_n     (arst_n),
      .dv_in      (dv_in),
      .src_in     (src_in),
      .data_in    (data_in),
      .pop        (pop),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .full       (full)
   );

   // Route table, looked up with the head tag
   route_map u_route_map (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_chan   (wr_chan),
      .wr_data   (wr_data),
      .src       (head_src),
      .chan_mask (chan_mask)
   );

   // Per-channel instruction issue
   dispatch_ctrl u_dispatch_ctrl (
      .clk_in     (clk_in),
      .arst_n     (arst_n),
      .head_valid (head_valid),
      .head_data  (head_data),
      .chan_mask  (chan_mask),
      .pop        (pop),
      .dv_out     (dv_out),
      .chan_out   (chan_out),
      .data_out   (data_out)
   );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
   parameter int PERIOD = 100
) (
   output logic clk_in
);
   // Free-running clock, starts low
   initial begin
      clk_in = 1'b0;
   end

   always begin
      #(PERIOD / 2);
      clk_in = ~clk_in;
   end

endmodule

// File: tests/dispatch_checker.sv
`timescale 1ns/1ns

module dispatch_checker (
   input  logic                    clk_in,
   input  logic                    arst_n,
   input  logic                    dv_in,
   input  dispatch_pkg::src_t      src_in,
   input  dispatch_pkg::data_t     data_in,
   input  logic                    full,
   input  logic                    wr_en,
   input  dispatch_pkg::reg_addr_t wr_addr,
   input  dispatch_pkg::reg_addr_t wr_chan,
   input  dispatch_pkg::reg_data_t wr_data,
   input  logic                    dv_out,
   input  dispatch_pkg::chan_t     chan_out,
   input  dispatch_pkg::data_t     data_out,
   output int                      err_cnt,
   output int                      seen_cnt,
   output int                      exp_left
);
   import dispatch_pkg::*;

   // Shadow copy of the route table
   logic       en_model  [N_CHAN];
   // Bit 3 set means no source
   logic [3:0] sel_model [N_CHAN];

   // Expected instructions in issue order
   chan_t exp_chan [$];
   data_t exp_data [$];

   int errors = 0;
   int seen   = 0;

   // --------------------
   // Model
   // --------------------
   task automatic mirror_write();
      int ch;
      ch = int'(wr_chan);
      // Channels past the table and unknown addresses change nothing
      if (ch < N_CHAN) begin
         if (wr_addr == CHAN_EN_ADDR) begin
            en_model[ch] = wr_data[0];
         end else if (wr_addr == CHAN_SRC_SEL_ADDR) begin
            sel_model[ch] = wr_data[3:0];
         end
      end
   endtask

   // One instruction per enabled channel bound to the source, lowest first
   task automatic expect_sample();
      for (int c = 0; c < N_CHAN; c++) begin
         if (en_model[c] && !sel_model[c][3] && (sel_model[c][2:0] == src_in)) begin
            exp_chan.push_back(chan_t'(c));
            exp_data.push_back(data_in);
         end
      end
   endtask

   task automatic compare_output();
      chan_t c;
      data_t d;
      seen++;
      if (exp_chan.size() == 0) begin
         $display("Unexpected instruction on channel %0d while none was due", chan_out);
         errors++;
      end else begin
         c = exp_chan.pop_front();
         d = exp_data.pop_front();
         if (chan_out !== c) begin
            $display("ERROR: chan_out expected %h got %h", c, chan_out);
            errors++;
         end
         if (data_out !== d) begin
            $display("ERROR: data_out expected %h got %h", d, data_out);
            errors++;
         end
      end
   endtask

   // --------------------
   // Per-edge sampling
   // --------------------
   always @(posedge clk_in) begin
      if (!arst_n) begin
         for (int c = 0; c < N_CHAN; c++) begin
            en_model[c]  = 1'b0;
            sel_model[c] = 4'h8;
         end
         exp_chan.delete();
         exp_data.delete();
      end else begin
         // Output first, a sample taken now cannot be issued yet
         if (dv_out) begin
            compare_output();
         end
         if (wr_en) begin
            mirror_write();
         end
         if (dv_in) begin
            // Bursts never exceed the queue depth, so no drop is due
            if (full) begin
               $display("Sample from source %0d was dropped by a full queue", src_in);
               errors++;
            end else begin
               expect_sample();
            end
         end
      end
      err_cnt  <= errors;
      seen_cnt <= seen;
      exp_left <= exp_chan.size();
   end

endmodule

// File: tests/dispatch_properties.sv
`timescale 1ns/1ns

module dispatch_properties (
   input logic                clk_in,
   input logic                arst_n,
   input logic                head_valid,
   input logic                pop,
   input logic                dv_out,
   input dispatch_pkg::chan_t chan_out
);

   // Instruction strobe and head release are exclusive
   a_no_dv_with_pop: assert property (@(posedge clk_in) disable iff (!arst_n)
      !(dv_out && pop))
      else $error("dv_out and pop were high in the same cycle");

   // One sample's instructions come back to back
   // Each must name a higher channel than the one before, so none repeats
   a_no_repeat_chan: assert property (@(posedge clk_in) disable iff (!arst_n)
      (dv_out && $past(dv_out)) |-> (chan_out > $past(chan_out)))
      else $error("channel %0d repeated or out of order within one sample", chan_out);

   // Head is only released while one is held
   a_pop_with_head: assert property (@(posedge clk_in) disable iff (!arst_n)
      pop |-> head_valid)
      else $error("pop raised with an empty queue");

endmodule

// Attach to every dispatcher instance
bind dispatch_ctrl dispatch_properties u_dispatch_properties (
   .clk_in     (clk_in),
   .arst_n     (arst_n),
   .head_valid (head_valid),
   .pop        (pop),
   .dv_out     (dv_out),
   .chan_out   (chan_out)
);

// File: tests/tb_instr_dispatch.sv
`timescale 1ns/1ns

module tb_instr_dispatch;
   import dispatch_pkg::*;

   // --------------------
   // Run limits
   // --------------------
   localparam int RAND_ROUNDS = 6;
   // Fixed tests send 70 samples, each random round at most one full queue
   localparam int MAX_SAMPLES = 70 + RAND_ROUNDS * FIFO_DEPTH;
   // Dispatch plus pop plus input gap per sample, then room for writes and drains
   localparam int CYCLE_LIMIT = MAX_SAMPLES * (N_CHAN + 2 + 4) + 4000;

   logic      clk_in;
   logic      arst_n;
   logic      dv_in;
   src_t      src_in;
   data_t     data_in;
   logic      wr_en;
   reg_addr_t wr_addr;
   reg_addr_t wr_chan;
   reg_data_t wr_data;
   logic      dv_out;
   chan_t     chan_out;
   data_t     data_out;
   logic      full;

   // Checker counts
   int err_cnt;
   int seen_cnt;
   int exp_left;

   int cycles       = 0;
   int tb_errs      = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int err_mark     = 0;
   int seen_mark    = 0;

   tb_clock #(.PERIOD(100)) u_tb_clock (.clk_in(clk_in));
   instr_dispatch u_instr_dispatch (.*);
   dispatch_checker u_dispatch_checker (.*);

   // Hard stop if the DUT stalls
   always @(posedge clk_in) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, instructions stopped coming", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   // --------------------
   // Stimulus tasks
   // --------------------
   task automatic write_reg(input reg_addr_t addr, input reg_addr_t chan, input reg_data_t data);
      @(posedge clk_in);
      wr_en   <= 1'b1;
      wr_addr <= addr;
      wr_chan <= chan;
      wr_data <= data;
      @(posedge clk_in);
      wr_en   <= 1'b0;
   endtask

   // Bind a channel to a source and switch it on
   task automatic route(input int chan, input int src);
      write_reg(CHAN_SRC_SEL_ADDR, reg_addr_t'(chan), reg_data_t'(src));
      write_reg(CHAN_EN_ADDR, reg_addr_t'(chan), 16'h0001);
   endtask

   task automatic clear_routes();
      for (int c = 0; c < N_CHAN; c++) begin
         write_reg(CHAN_EN_ADDR, reg_addr_t'(c), 16'h0000);
         write_reg(CHAN_SRC_SEL_ADDR, reg_addr_t'(c), 16'h0008);
      end
   endtask

   // Negative source picks a random one per sample
   task automatic send_burst(input int n, input int src);
      src_t s;
      for (int i = 0; i < n; i++) begin
         s = (src < 0) ? src_t'($urandom_range(0, N_SRC - 1)) : src_t'(src);
         @(posedge clk_in);
         dv_in   <= 1'b1;
         src_in  <= s;
         data_in <= data_t'($urandom());
         @(posedge clk_in);
         dv_in   <= 1'b0;
         repeat ($urandom_range(0, 3)) @(posedge clk_in);
      end
   endtask

   // Idle means nothing due, nothing queued, nothing on the output
   task automatic wait_drain();
      int quiet;
      quiet = 0;
      while (quiet < 4) begin
         @(posedge clk_in);
         if (exp_left == 0 && !u_instr_dispatch.head_valid && !dv_out) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR: %s expected %h got %h", name, exp, got);
         tb_errs++;
      end
   endtask

   // Negative count skips the instruction tally
   task automatic finish_test(input string name, input int want);
      int errs;
      int got;
      wait_drain();
      got = seen_cnt - seen_mark;
      if (want >= 0 && got != want) begin
         $display("%s expected %0d instructions but %0d were issued", name, want, got);
         tb_errs++;
      end
      errs = err_cnt + tb_errs - err_mark;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "FAILED", errs);
      err_mark  = err_cnt + tb_errs;
      seen_mark = seen_cnt;
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      arst_n  <= 1'b0;
      dv_in   <= 1'b0;
      src_in  <= '0;
      data_in <= '0;
      wr_en   <= 1'b0;
      wr_addr <= '0;
      wr_chan <= '0;
      wr_data <= '0;
      void'($urandom(2));
      repeat (10) @(posedge clk_in);
      arst_n <= 1'b1;
      @(posedge clk_in);

      // Outputs quiet after reset, nothing issued with an empty table
      check_value("dv_out", 32'(dv_out), 32'h0);
      check_value("full", 32'(full), 32'h0);
      check_value("chan_out", 32'(chan_out), 32'h0);
      check_value("data_out", 32'(data_out), 32'h0);
      repeat (20) @(posedge clk_in);
      finish_test("reset state", 0);

      route(2, 5);
      send_burst(12, 5);
      finish_test("single route", 12);

      // Three channels on one source
      clear_routes();
      route(1, 3);
      route(4, 3);
      route(7, 3);
      send_burst(10, 3);
      finish_test("fan-out", 30);

      clear_routes();
      // Bound but disabled
      write_reg(CHAN_SRC_SEL_ADDR, 16'd0, 16'd6);
      // Past the table, would alias channels 0, 1 and 4 if decoded
      write_reg(CHAN_EN_ADDR, 16'd8, 16'd1);
      write_reg(CHAN_SRC_SEL_ADDR, 16'd9, 16'd1);
      write_reg(CHAN_SRC_SEL_ADDR, 16'd12, 16'd1);
      // Enabled with no source, plus an unknown address
      write_reg(CHAN_EN_ADDR, 16'd3, 16'd1);
      write_reg(16'h0012, 16'd5, 16'd1);
      send_burst(12, -1);
      finish_test("unrouted samples", 0);

      // Channel 2 moves from source 4 to source 1, then to no source
      clear_routes();
      route(2, 4);
      send_burst(6, 4);
      send_burst(6, 1);
      wait_drain();
      route(2, 1);
      send_burst(6, 4);
      send_burst(6, 1);
      wait_drain();
      write_reg(CHAN_SRC_SEL_ADDR, 16'd2, 16'(NO_SRC));
      send_burst(6, 4);
      send_burst(6, 1);
      finish_test("remap", 12);

      for (int r = 0; r < RAND_ROUNDS; r++) begin
         clear_routes();
         repeat (12) begin
            write_reg(($urandom_range(0, 1) != 0) ? CHAN_SRC_SEL_ADDR : CHAN_EN_ADDR,
                      reg_addr_t'($urandom_range(0, N_CHAN + 1)),
                      reg_data_t'($urandom_range(0, 15)));
         end
         send_burst(int'($urandom_range(1, FIFO_DEPTH)), -1);
         wait_drain();
      end
      if (exp_left != 0) begin
         $display("Random mix left %0d expected instructions unissued", exp_left);
         tb_errs++;
      end
      finish_test("random mix", -1);

      $display("Tests run: %0d, failed: %0d, errors: %0d",
               tests_run, tests_failed, err_cnt + tb_errs);
      if (tests_failed == 0 && (err_cnt + tb_errs) == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: tb.f
src/dispatch_pkg.sv
src/sample_fifo.sv
src/route_map.sv
src/dispatch_ctrl.sv
src/instr_dispatch.sv
tests/tb_clock.sv
tests/dispatch_checker.sv
tests/dispatch_properties.sv
tests/tb_instr_dispatch.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_instr_dispatch -f tb.f \
   && ./obj_dir/Vtb_instr_dispatch > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failures found" sim.log && { echo "Simulation failed"; exit 1; }
# A run cut short by an assertion prints neither line
grep -q "All tests passed!" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
